// ==== group_sum.sv ====
module group_sum
    import idsum_pkg::*;
#(
    parameter int repeat_count = 2
) (
    input  logic    clock,
    input  logic    reset,
    input  logic    issue_valid,
    input  num_t    issue_bound,
    input  digits_t issue_digits,
    output logic    part_valid,
    output sum_t    part_sum
);

    digits_t block;
    logic    s0_en;
    num_t    s0_base;
    num_t    s0_lb;
    num_t    s0_ub_cap;
    num_t    s0_ub_div;
    num_t    s0_ub;

    logic    s1_en;
    num_t    s1_base;
    num_t    s1_lb;
    num_t    s1_ub;

    logic    s2_en;
    num_t    s2_base;
    num_t    s2_ends;
    num_t    s2_count;

    logic    s3_en;
    num_t    s3_base;
    sum_t    s3_half;

    logic [3:0] valid_sr;

    always_comb begin
        block = digits_t'(issue_digits / repeat_count);
        s0_en = ((issue_digits % repeat_count) == 0) && (block != '0);
        s0_base = repunit_base(block, repeat_count);
        s0_lb = (block == '0) ? num_t'(1) : pow10(block - 1);
        s0_ub_cap = pow10(block) - num_t'(1);  // Largest block of this size
        s0_ub_div = issue_bound / s0_base;     // Largest block within bound
        s0_ub = (s0_ub_cap < s0_ub_div) ? s0_ub_cap : s0_ub_div;
    end

    // Stage 1 block bounds and base
    always_ff @(posedge clock) begin
        s1_en   <= s0_en;
        s1_base <= s0_base;
        s1_lb   <= s0_lb;
        s1_ub   <= s0_ub;
    end

    // Stage 2 series count and end sum
    always_ff @(posedge clock) begin
        s2_en    <= s1_en && (s1_ub >= s1_lb); // Empty block range gives zero
        s2_base  <= s1_base;
        s2_ends  <= s1_lb + s1_ub;
        s2_count <= s1_ub - s1_lb + num_t'(1);
    end

    // Stage 3 arithmetic series
    always_ff @(posedge clock) begin
        s3_en   <= s2_en;
        s3_base <= s2_base;
        s3_half <= (sum_t'(s2_ends) * sum_t'(s2_count)) >> 1;
    end

    // Stage 4 scale blocks back to full numbers
    always_ff @(posedge clock) begin
        part_sum <= s3_en ? sum_t'(s3_base) * s3_half : '0;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[2:0], issue_valid};
        end
    end

    assign part_valid = valid_sr[3];

endmodule

// ==== idsum_pkg.sv ====
package idsum_pkg;

    typedef logic [39:0] num_t;    // Bound or block value, 12 decimal digits
    typedef logic [95:0] sum_t;    // Products and accumulated sums
    typedef logic [3:0]  digits_t; // Decimal digit length, 1 to 12

    localparam int max_digits = 12;

    // Ten to the power p, for p up to max_digits
    function automatic num_t pow10(input int unsigned p);
        num_t r;
        r = num_t'(1);
        for (int i = 0; i < max_digits; i++) begin
            if (i < p) begin
                r = r * num_t'(10);
            end
        end
        return r;
    endfunction

    // Sum of 10^(b*i) for i in 0 .. count-1
    function automatic num_t repunit_base(
        input int unsigned b,
        input int unsigned count
    );
        num_t r;
        r = '0;
        for (int i = 0; i < max_digits; i++) begin
            if (i < count) begin
                r = r + pow10(b * i);
            end
        end
        return r;
    endfunction

endpackage

// ==== prefix_sum.sv ====
module prefix_sum
    import idsum_pkg::*;
#(
    parameter int repeat_count = 2
) (
    input  logic clock,
    input  logic reset,
    input  logic pfx_start,
    input  num_t pfx_bound,
    output logic pfx_done,
    output sum_t pfx_sum
);

    typedef enum logic [1:0] {
        idle,
        issue,
        drain
    } state_t;

    state_t  state;
    digits_t digit;
    digits_t rx_count;
    num_t    bound_q;
    sum_t    acc;

    logic    issue_valid;
    num_t    issue_bound;
    digits_t issue_digits;
    logic    part_valid;
    sum_t    part_sum;

    assign issue_valid  = (state == issue);
    assign issue_bound  = bound_q;
    assign issue_digits = digit;

    group_sum #(
        .repeat_count(repeat_count)
    ) u_group_sum (
        .clock       (clock),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_bound (issue_bound),
        .issue_digits(issue_digits),
        .part_valid  (part_valid),
        .part_sum    (part_sum)
    );

    always_ff @(posedge clock) begin
        if (state == idle && pfx_start) begin
            bound_q <= pfx_bound;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= idle;
            digit    <= '0;
            rx_count <= '0;
            pfx_done <= 1'b0;
            acc      <= '0;
        end else begin
            pfx_done <= 1'b0;
            if (part_valid) begin
                acc      <= acc + part_sum;
                rx_count <= rx_count + digits_t'(1);
                if (rx_count == digits_t'(max_digits - 1)) begin // Last length back
                    pfx_done <= 1'b1;
                    state    <= idle;
                end
            end
            case (state)
                idle: begin
                    if (pfx_start) begin
                        state    <= issue;
                        digit    <= digits_t'(1);
                        rx_count <= '0;
                        acc      <= '0;
                    end
                end
                issue: begin
                    digit <= digit + digits_t'(1);
                    if (digit == digits_t'(max_digits)) begin
                        state <= drain;
                    end
                end
                default: ; // Drain waits on the pipeline
            endcase
        end
    end

    assign pfx_sum = acc;

endmodule

// ==== range_ctrl.sv ====
module range_ctrl
    import idsum_pkg::*;
(
    input  logic clock,
    input  logic reset,
    input  logic start,
    input  num_t lo,
    input  num_t hi,
    input  logic clear,
    output logic busy,
    output logic done,
    output sum_t range_sum,
    output sum_t total,
    output logic pfx_start,
    output num_t pfx_bound,
    input  logic pfx_done,
    input  sum_t pfx_sum
);

    typedef enum logic [2:0] {
        idle,
        run_hi,
        run_lo,
        finish,
        empty
    } state_t;

    state_t state;
    num_t   lo_q;
    num_t   lo_m1;
    sum_t   hi_sum;

    // Prefix below lo, saturating at zero
    assign lo_m1 = (lo_q == '0) ? '0 : lo_q - num_t'(1);

    assign busy = (state != idle);

    // Second run starts as the first one reports
    assign pfx_start = (state == idle && start && lo <= hi) ||
                       (state == run_hi && pfx_done);
    assign pfx_bound = (state == idle) ? hi : lo_m1;

    always_ff @(posedge clock) begin
        if (state == idle && start) begin
            lo_q <= lo;
        end
        if (state == run_hi && pfx_done) begin
            hi_sum <= pfx_sum;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= idle;
            done      <= 1'b0;
            range_sum <= '0;
            total     <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                idle: begin
                    if (clear) begin
                        total <= '0;
                    end
                    if (start) begin
                        state <= (lo <= hi) ? run_hi : empty;
                    end
                end
                run_hi: begin
                    if (pfx_done) begin
                        state <= run_lo;
                    end
                end
                run_lo: begin
                    if (pfx_done) begin
                        range_sum <= hi_sum - pfx_sum;
                        state     <= finish;
                    end
                end
                finish: begin
                    done  <= 1'b1;
                    total <= total + range_sum; // Visible with done
                    state <= idle;
                end
                empty: begin
                    done      <= 1'b1;
                    range_sum <= '0;
                    state     <= idle;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

// ==== repid_top.f ====
+incdir+.
idsum_pkg.sv
group_sum.sv
prefix_sum.sv
range_ctrl.sv
repid_top.sv
tb_repid.sv

// ==== repid_top.sv ====
module repid_top
    import idsum_pkg::*;
#(
    parameter int repeat_count = 2
) (
    input  logic clock,
    input  logic reset,
    input  logic start,
    input  num_t lo,
    input  num_t hi,
    input  logic clear,
    output logic busy,
    output logic done,
    output sum_t range_sum,
    output sum_t total
);

    logic pfx_start;
    num_t pfx_bound;
    logic pfx_done;
    sum_t pfx_sum;

    range_ctrl u_range_ctrl (
        .clock    (clock),
        .reset    (reset),
        .start    (start),
        .lo       (lo),
        .hi       (hi),
        .clear    (clear),
        .busy     (busy),
        .done     (done),
        .range_sum(range_sum),
        .total    (total),
        .pfx_start(pfx_start),
        .pfx_bound(pfx_bound),
        .pfx_done (pfx_done),
        .pfx_sum  (pfx_sum)
    );

    // Shared between the hi and lo runs
    prefix_sum #(
        .repeat_count(repeat_count)
    ) u_prefix_sum (
        .clock    (clock),
        .reset    (reset),
        .pfx_start(pfx_start),
        .pfx_bound(pfx_bound),
        .pfx_done (pfx_done),
        .pfx_sum  (pfx_sum)
    );

endmodule

// ==== tb_repid_model.svh ====
`ifndef TB_REPID_MODEL_SVH
`define TB_REPID_MODEL_SVH

// True when the decimal digits of n are one block written count times
function automatic bit is_repeated_block(input longint unsigned n, input int count);
    string s;
    int    blk;
    s = $sformatf("%0d", n);
    if (s.len() % count != 0) begin
        return 1'b0;
    end
    blk = s.len() / count;
    for (int i = 1; i < count; i++) begin
        if (s.substr(i * blk, i * blk + blk - 1) != s.substr(0, blk - 1)) begin
            return 1'b0;
        end
    end
    return 1'b1;
endfunction

// Brute-force sum over lo..hi, empty when lo is above hi
function automatic sum_t sum_repeated_range(
    input longint unsigned lo_value,
    input longint unsigned hi_value,
    input int              count
);
    sum_t acc;
    acc = '0;
    for (longint unsigned n = lo_value; n <= hi_value; n++) begin
        if (is_repeated_block(n, count)) begin
            acc = acc + sum_t'(n);
        end
    end
    return acc;
endfunction

`endif

// ==== tb_repid.sv ====
module tb_repid
    import idsum_pkg::*;
();

    localparam int repeat_count = 2;
    localparam int wait_limit   = 100;   // Cycles allowed per wait for done
    localparam int run_latency  = 36;    // Two prefix runs plus 2
    localparam int empty_latency = 2;

    logic clock;
    logic reset;
    logic start;
    num_t lo;
    num_t hi;
    logic clear;
    logic busy;
    logic done;
    sum_t range_sum;
    sum_t total;

    sum_t        expected_total;

    `include "tb_repid_model.svh"

    repid_top #(
        .repeat_count(repeat_count)
    ) dut (
        .clock    (clock),
        .reset    (reset),
        .start    (start),
        .lo       (lo),
        .hi       (hi),
        .clear    (clear),
        .busy     (busy),
        .done     (done),
        .range_sum(range_sum),
        .total    (total)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic fail_now(input string what);
        $display("%s", what);
        $display(">>> FAIL");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_value(input string name, input sum_t got, input sum_t exp);
        assert (got == exp) else begin
            fail_now($sformatf("Mismatch at %0t: %s got %0d expected %0d",
                               $time, name, got, exp));
        end
    endtask

    // Samples at the falling edge, counts cycles from the last drive edge
    task automatic wait_done(output int cycles);
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
            if (cycles > wait_limit) begin
                fail_now("Timeout while waiting for done");
            end
        end while (!done);
    endtask

    task automatic pulse_start(input num_t lo_value, input num_t hi_value);
        @(posedge clock);
        lo    <= lo_value;
        hi    <= hi_value;
        start <= 1'b1;
        @(posedge clock);
        start <= 1'b0;
    endtask

    task automatic apply_clear();
        @(posedge clock);
        clear <= 1'b1;
        @(posedge clock);
        clear <= 1'b0;
        @(negedge clock);
        expected_total = '0;
        check_value("total", total, expected_total);
    endtask

    task automatic check_range(input num_t lo_value, input num_t hi_value);
        sum_t expected;
        int   cycles;
        int   latency;
        expected = sum_repeated_range(lo_value, hi_value, repeat_count);
        latency  = (lo_value <= hi_value) ? run_latency : empty_latency;
        pulse_start(lo_value, hi_value);
        wait_done(cycles);
        check_value("done latency", sum_t'(cycles), sum_t'(latency));
        check_value("range_sum", range_sum, expected);
        expected_total = expected_total + expected;
        check_value("total", total, expected_total);
    endtask

    task automatic idle_after_reset();
        @(negedge clock);
        check_value("busy", sum_t'(busy), '0);
        check_value("done", sum_t'(done), '0);
        check_value("total", total, '0);
    endtask

    task automatic fixed_ranges();
        check_range(40'd11, 40'd22);
        check_range(40'd95, 40'd115);
        check_range(40'd1, 40'd9);
        check_range(40'd998, 40'd1012);
        check_range(40'd0, 40'd100);
        check_range(40'd1000, 40'd9999);
    endtask

    task automatic random_ranges();
        longint unsigned p;
        longint unsigned span;
        longint unsigned back;
        longint unsigned lo_value;
        longint unsigned hi_value;
        for (int i = 0; i < 20; i++) begin
            span = $urandom % 20001;
            if (i % 2 == 0) begin
                p = 100;
                repeat ((i / 2) % 6) p = p * 10;   // Power of ten to straddle
                back = $urandom % (span + 1);
                lo_value = (p > back) ? p - back : 1;
            end else begin
                lo_value = 1 + ($urandom % 10000000);
            end
            hi_value = lo_value + span;
            if (hi_value > 10000000) begin
                hi_value = 10000000;
            end
            check_range(num_t'(lo_value), num_t'(hi_value));
        end
    endtask

    task automatic empty_and_single_ranges();
        check_range(40'd500, 40'd400);   // Empty range
        check_range(40'd6464, 40'd6464);
        check_value("range_sum", range_sum, sum_t'(6464));
    endtask

    task automatic total_and_clear();
        apply_clear();
        check_range(40'd11, 40'd99);
        check_range(40'd1000, 40'd2000);
        check_range(40'd123000, 40'd124000);
        apply_clear();
    endtask

    task automatic start_while_busy();
        sum_t expected;
        int   cycles;
        expected = sum_repeated_range(1000, 5000, repeat_count);
        pulse_start(40'd1000, 40'd5000);
        repeat (4) @(posedge clock);
        @(negedge clock);
        check_value("busy", sum_t'(busy), sum_t'(1));
        @(posedge clock);
        lo    <= 40'd20;
        hi    <= 40'd90;
        start <= 1'b1;
        @(posedge clock);
        start <= 1'b0;
        wait_done(cycles);
        check_value("done latency", sum_t'(cycles), sum_t'(run_latency - 6));
        check_value("range_sum", range_sum, expected);
        expected_total = expected_total + expected;
        check_value("total", total, expected_total);
        repeat (50) begin
            @(negedge clock);
            assert (!done) else begin
                fail_now("A second done arrived for a start given while busy");
            end
        end
        check_value("busy", sum_t'(busy), '0);
    endtask

    initial begin
        void'($urandom(32'haaa18cd0));
        expected_total = '0;
        reset = 1'b1;
        start = 1'b0;
        lo    = '0;
        hi    = '0;
        clear = 1'b0;
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        idle_after_reset();
        fixed_ranges();
        random_ranges();
        empty_and_single_ranges();
        total_and_clear();
        start_while_busy();
        $display(">>> PASS");
        $finish;
    end

endmodule
